// ==== design/scale_geom_pkg.sv ====
package scale_geom_pkg;

  localparam int src_width  = 640;
  localparam int src_height = 480;
  localparam int dst_width  = 533;
  localparam int dst_height = 400;

  localparam int dst_pixels = dst_width * dst_height;  // One write per destination pixel

  localparam int coord_w    = 10;
  localparam int src_addr_w = 19;
  localparam int dst_addr_w = 19;
  localparam int pixel_w    = 8;

  typedef logic [coord_w-1:0]    coord_t;
  typedef logic [src_addr_w-1:0] src_addr_t;
  typedef logic [dst_addr_w-1:0] dst_addr_t;
  typedef logic [pixel_w-1:0]    pixel_t;

endpackage

// ==== design/scale_fixed_pkg.sv ====
package scale_fixed_pkg;

  // Coordinates carry 12 fraction bits after mapping into the source image
  localparam int frac_w   = 12;
  localparam int scale_w  = 13;
  localparam int mapped_w = scale_geom_pkg::coord_w + scale_w;
  localparam int int_w    = mapped_w - frac_w;  // Integer part of a mapped coordinate

  localparam logic [scale_w-1:0] scale_x = 13'd4918;  // 640/533 in units of 1/4096
  localparam logic [scale_w-1:0] scale_y = 13'd4915;  // 480/400 in units of 1/4096

  localparam int weight_w = frac_w + 1;  // Holds 4096 when the fraction is zero
  localparam int prod_w   = 2 * weight_w;
  localparam int acc_w    = 32;

  localparam logic [weight_w-1:0] weight_one = 13'd4096;

  typedef logic [frac_w-1:0]   frac_t;
  typedef logic [weight_w-1:0] weight_t;
  typedef logic [prod_w-1:0]   prod_t;
  typedef logic [acc_w-1:0]    acc_t;

  typedef enum logic [1:0] {
    idle,
    scan,
    drain
  } scan_state_t;

endpackage

// ==== design/raster_scan.sv ====
module raster_scan (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic                   last_write,
  output scale_geom_pkg::coord_t dst_x,
  output scale_geom_pkg::coord_t dst_y,
  output logic                   phase,
  output logic                   pix_valid,
  output logic                   busy,
  output logic                   done
);

  scale_fixed_pkg::scan_state_t state;
  logic                         row_end;
  logic                         frame_end;

  assign row_end   = (dst_x == scale_geom_pkg::coord_t'(scale_geom_pkg::dst_width));
  assign frame_end = row_end && (dst_y == scale_geom_pkg::coord_t'(scale_geom_pkg::dst_height));

  assign pix_valid = (state == scale_fixed_pkg::scan) && !phase;  // One entry per two cycles
  assign busy      = (state != scale_fixed_pkg::idle);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= scale_fixed_pkg::idle;
    else if (start)
      state <= scale_fixed_pkg::scan;  // Also restarts a running frame
    else
    begin
      case (state)
        scale_fixed_pkg::scan:
        begin
          if (phase && frame_end)
            state <= scale_fixed_pkg::drain;
        end
        scale_fixed_pkg::drain:
        begin
          if (last_write)
            state <= scale_fixed_pkg::idle;
        end
        default:
          state <= scale_fixed_pkg::idle;
      endcase
    end
  end

  // Coordinates rest at (1,1) so the mapper never sees a zero coordinate
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dst_x <= scale_geom_pkg::coord_t'(1);
      dst_y <= scale_geom_pkg::coord_t'(1);
      phase <= 1'b0;
    end
    else if (start)
    begin
      dst_x <= scale_geom_pkg::coord_t'(1);
      dst_y <= scale_geom_pkg::coord_t'(1);
      phase <= 1'b0;
    end
    else if (state == scale_fixed_pkg::scan)
    begin
      phase <= ~phase;
      if (phase)
      begin
        if (row_end)
        begin
          dst_x <= scale_geom_pkg::coord_t'(1);
          if (!frame_end)
            dst_y <= dst_y + 1'b1;
        end
        else
          dst_x <= dst_x + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      done <= 1'b0;
    else
      done <= (state == scale_fixed_pkg::drain) && last_write && !start;
  end

endmodule

// ==== design/coord_mapper.sv ====
module coord_mapper (
  input  logic                      clk,
  input  logic                      rst_n,
  input  scale_geom_pkg::coord_t    dst_x,
  input  scale_geom_pkg::coord_t    dst_y,
  input  logic                      phase,
  input  logic                      pix_valid,
  output scale_geom_pkg::src_addr_t src_addr_left,
  output scale_geom_pkg::src_addr_t src_addr_right,
  output scale_fixed_pkg::frac_t    frac_x,
  output scale_fixed_pkg::frac_t    frac_y,
  output scale_geom_pkg::dst_addr_t out_addr,
  output logic                      row_sel,
  output logic                      stage_valid
);

  logic [scale_fixed_pkg::mapped_w-1:0] mx;
  logic [scale_fixed_pkg::mapped_w-1:0] my;
  logic [scale_fixed_pkg::int_w-1:0]    ix;
  logic [scale_fixed_pkg::int_w-1:0]    iy;
  logic [scale_fixed_pkg::int_w-1:0]    src_row;
  scale_geom_pkg::src_addr_t            src_base;

  assign mx = dst_x * scale_fixed_pkg::scale_x;
  assign my = dst_y * scale_fixed_pkg::scale_y;

  assign ix = mx[scale_fixed_pkg::mapped_w-1:scale_fixed_pkg::frac_w];
  assign iy = my[scale_fixed_pkg::mapped_w-1:scale_fixed_pkg::frac_w];

  // Phase 0 addresses the upper neighbour row, phase 1 the lower one
  assign src_row  = iy - 1'b1 + phase;
  assign src_base = scale_geom_pkg::src_addr_t'(src_row * scale_geom_pkg::src_width + ix);

  always_ff @(posedge clk)
  begin
    src_addr_left  <= src_base - 1'b1;  // Column ix-1
    src_addr_right <= src_base;
    frac_x         <= mx[scale_fixed_pkg::frac_w-1:0];
    frac_y         <= my[scale_fixed_pkg::frac_w-1:0];
    out_addr       <= scale_geom_pkg::dst_addr_t'((dst_y - 1'b1) * scale_geom_pkg::dst_width
                                                  + dst_x - 1'b1);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      row_sel     <= 1'b0;
      stage_valid <= 1'b0;
    end
    else
    begin
      row_sel     <= phase;
      stage_valid <= pix_valid;
    end
  end

endmodule

// ==== design/pixel_gather.sv ====
module pixel_gather (
  input  logic                      clk,
  input  logic                      rst_n,
  input  scale_geom_pkg::pixel_t    src_data_left,
  input  scale_geom_pkg::pixel_t    src_data_right,
  input  scale_fixed_pkg::frac_t    frac_x,
  input  scale_fixed_pkg::frac_t    frac_y,
  input  scale_geom_pkg::dst_addr_t out_addr,
  input  logic                      row_sel,
  input  logic                      stage_valid,
  output scale_geom_pkg::pixel_t    p00,
  output scale_geom_pkg::pixel_t    p01,
  output scale_geom_pkg::pixel_t    p10,
  output scale_geom_pkg::pixel_t    p11,
  output scale_fixed_pkg::frac_t    frac_x_q,
  output scale_fixed_pkg::frac_t    frac_y_q,
  output scale_geom_pkg::dst_addr_t addr_q,
  output logic                      quad_valid
);

  scale_fixed_pkg::frac_t    side_frac_x;
  scale_fixed_pkg::frac_t    side_frac_y;
  scale_geom_pkg::dst_addr_t side_addr;
  logic                      side_valid;
  logic                      side_row;
  logic                      upper_held;

  // Side information waits one cycle for the memory read
  always_ff @(posedge clk)
  begin
    side_frac_x <= frac_x;
    side_frac_y <= frac_y;
    side_addr   <= out_addr;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      side_valid <= 1'b0;
      side_row   <= 1'b0;
      upper_held <= 1'b0;
    end
    else
    begin
      side_valid <= stage_valid;
      side_row   <= row_sel;
      upper_held <= side_valid && !side_row;
    end
  end

  always_ff @(posedge clk)
  begin
    if (side_valid && !side_row)
    begin
      p00      <= src_data_left;  // Upper pair of the quad
      p01      <= src_data_right;
      frac_x_q <= side_frac_x;
      frac_y_q <= side_frac_y;
      addr_q   <= side_addr;
    end
  end

  // Lower pair arrives straight from memory in the following cycle
  assign p10        = src_data_left;
  assign p11        = src_data_right;
  assign quad_valid = upper_held && side_row;

endmodule

// ==== design/bilinear_blend.sv ====
module bilinear_blend (
  input  logic                      clk,
  input  logic                      rst_n,
  input  scale_geom_pkg::pixel_t    p00,
  input  scale_geom_pkg::pixel_t    p01,
  input  scale_geom_pkg::pixel_t    p10,
  input  scale_geom_pkg::pixel_t    p11,
  input  scale_fixed_pkg::frac_t    frac_x_q,
  input  scale_fixed_pkg::frac_t    frac_y_q,
  input  scale_geom_pkg::dst_addr_t addr_q,
  input  logic                      quad_valid,
  output scale_geom_pkg::dst_addr_t dst_addr,
  output scale_geom_pkg::pixel_t    dst_data,
  output logic                      dst_wren,
  output logic                      last_write
);

  scale_fixed_pkg::weight_t  wx0;
  scale_fixed_pkg::weight_t  wx1;
  scale_fixed_pkg::weight_t  wy0;
  scale_fixed_pkg::weight_t  wy1;
  scale_fixed_pkg::prod_t    w00;
  scale_fixed_pkg::prod_t    w01;
  scale_fixed_pkg::prod_t    w10;
  scale_fixed_pkg::prod_t    w11;
  scale_geom_pkg::pixel_t    q00;
  scale_geom_pkg::pixel_t    q01;
  scale_geom_pkg::pixel_t    q10;
  scale_geom_pkg::pixel_t    q11;
  scale_fixed_pkg::acc_t     t00;
  scale_fixed_pkg::acc_t     t01;
  scale_fixed_pkg::acc_t     t10;
  scale_fixed_pkg::acc_t     t11;
  scale_fixed_pkg::acc_t     sum;
  scale_geom_pkg::dst_addr_t addr1;
  scale_geom_pkg::dst_addr_t addr2;
  logic                      v1;
  logic                      v2;

  assign wx1 = scale_fixed_pkg::weight_t'(frac_x_q);
  assign wy1 = scale_fixed_pkg::weight_t'(frac_y_q);
  assign wx0 = scale_fixed_pkg::weight_one - wx1;  // 13 bits so a zero fraction gives 4096
  assign wy0 = scale_fixed_pkg::weight_one - wy1;

  always_ff @(posedge clk)
  begin
    w00   <= wx0 * wy0;
    w01   <= wx1 * wy0;
    w10   <= wx0 * wy1;
    w11   <= wx1 * wy1;
    q00   <= p00;
    q01   <= p01;
    q10   <= p10;
    q11   <= p11;
    addr1 <= addr_q;
  end

  always_ff @(posedge clk)
  begin
    t00   <= scale_fixed_pkg::acc_t'(w00) * q00;
    t01   <= scale_fixed_pkg::acc_t'(w01) * q01;
    t10   <= scale_fixed_pkg::acc_t'(w10) * q10;
    t11   <= scale_fixed_pkg::acc_t'(w11) * q11;
    addr2 <= addr1;
  end

  // Weights sum to 2^24 so the sum never leaves 32 bits
  assign sum = t00 + t01 + t10 + t11;

  always_ff @(posedge clk)
  begin
    dst_data <= sum[scale_fixed_pkg::acc_w-1:scale_fixed_pkg::acc_w-scale_geom_pkg::pixel_w];
    dst_addr <= addr2;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      v1         <= 1'b0;
      v2         <= 1'b0;
      dst_wren   <= 1'b0;
      last_write <= 1'b0;
    end
    else
    begin
      v1         <= quad_valid;
      v2         <= v1;
      dst_wren   <= v2;
      last_write <= v2 &&
                    (addr2 == scale_geom_pkg::dst_addr_t'(scale_geom_pkg::dst_pixels - 1));
    end
  end

endmodule

// ==== design/image_scaler.sv ====
module image_scaler (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  output scale_geom_pkg::src_addr_t src_addr_left,
  output scale_geom_pkg::src_addr_t src_addr_right,
  input  scale_geom_pkg::pixel_t    src_data_left,
  input  scale_geom_pkg::pixel_t    src_data_right,
  output scale_geom_pkg::dst_addr_t dst_addr,
  output scale_geom_pkg::pixel_t    dst_data,
  output logic                      dst_wren,
  output logic                      busy,
  output logic                      done
);

  scale_geom_pkg::coord_t    dst_x;
  scale_geom_pkg::coord_t    dst_y;
  logic                      phase;
  logic                      pix_valid;
  scale_fixed_pkg::frac_t    frac_x;
  scale_fixed_pkg::frac_t    frac_y;
  scale_geom_pkg::dst_addr_t out_addr;
  logic                      row_sel;
  logic                      stage_valid;
  scale_geom_pkg::pixel_t    p00;
  scale_geom_pkg::pixel_t    p01;
  scale_geom_pkg::pixel_t    p10;
  scale_geom_pkg::pixel_t    p11;
  scale_fixed_pkg::frac_t    frac_x_q;
  scale_fixed_pkg::frac_t    frac_y_q;
  scale_geom_pkg::dst_addr_t addr_q;
  logic                      quad_valid;
  logic                      last_write;

  raster_scan u_raster_scan (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .last_write (last_write),
    .dst_x      (dst_x),
    .dst_y      (dst_y),
    .phase      (phase),
    .pix_valid  (pix_valid),
    .busy       (busy),
    .done       (done)
  );

  coord_mapper u_coord_mapper (
    .clk            (clk),
    .rst_n          (rst_n),
    .dst_x          (dst_x),
    .dst_y          (dst_y),
    .phase          (phase),
    .pix_valid      (pix_valid),
    .src_addr_left  (src_addr_left),
    .src_addr_right (src_addr_right),
    .frac_x         (frac_x),
    .frac_y         (frac_y),
    .out_addr       (out_addr),
    .row_sel        (row_sel),
    .stage_valid    (stage_valid)
  );

  pixel_gather u_pixel_gather (
    .clk            (clk),
    .rst_n          (rst_n),
    .src_data_left  (src_data_left),
    .src_data_right (src_data_right),
    .frac_x         (frac_x),
    .frac_y         (frac_y),
    .out_addr       (out_addr),
    .row_sel        (row_sel),
    .stage_valid    (stage_valid),
    .p00            (p00),
    .p01            (p01),
    .p10            (p10),
    .p11            (p11),
    .frac_x_q       (frac_x_q),
    .frac_y_q       (frac_y_q),
    .addr_q         (addr_q),
    .quad_valid     (quad_valid)
  );

  bilinear_blend u_bilinear_blend (
    .clk        (clk),
    .rst_n      (rst_n),
    .p00        (p00),
    .p01        (p01),
    .p10        (p10),
    .p11        (p11),
    .frac_x_q   (frac_x_q),
    .frac_y_q   (frac_y_q),
    .addr_q     (addr_q),
    .quad_valid (quad_valid),
    .dst_addr   (dst_addr),
    .dst_data   (dst_data),
    .dst_wren   (dst_wren),
    .last_write (last_write)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ns;

  localparam int half_period_ns = 50;
  localparam int reset_cycles   = 4;

  initial
  begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // Released away from the active edge
  end

endmodule

// ==== verification/image_scaler_asserts.sv ====
module image_scaler_asserts (
  input logic                      clk,
  input logic                      rst_n,
  input scale_geom_pkg::src_addr_t src_addr_left,
  input scale_geom_pkg::src_addr_t src_addr_right,
  input scale_geom_pkg::dst_addr_t dst_addr,
  input logic                      dst_wren,
  input logic                      busy,
  input logic                      done
);

  timeunit 1ns;
  timeprecision 1ns;

  localparam int src_pixels = scale_geom_pkg::src_width * scale_geom_pkg::src_height;

  assert property (@(posedge clk) disable iff (!rst_n) dst_wren |-> busy)
    else $error("Destination write while the scaler is not busy");

  assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("Done strobe longer than one cycle");

  assert property (@(posedge clk) disable iff (!rst_n) !(done && dst_wren))
    else $error("Done strobe together with a destination write");

  assert property (@(posedge clk) disable iff (!rst_n)
    dst_wren |-> (dst_addr < scale_geom_pkg::dst_addr_t'(scale_geom_pkg::dst_pixels)))
    else $error("Destination address beyond the frame");

  // Both halves of the neighbour pair must stay inside the source image
  assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> (src_addr_left < scale_geom_pkg::src_addr_t'(src_pixels)) &&
             (src_addr_right < scale_geom_pkg::src_addr_t'(src_pixels)))
    else $error("Source address beyond the image");

endmodule

bind image_scaler image_scaler_asserts u_image_scaler_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .src_addr_left  (src_addr_left),
  .src_addr_right (src_addr_right),
  .dst_addr       (dst_addr),
  .dst_wren       (dst_wren),
  .busy           (busy),
  .done           (done)
);

// ==== verification/image_scaler_tb.sv ====
module image_scaler_tb;

  timeunit 1ns;
  timeprecision 1ns;

  localparam int     src_w        = scale_geom_pkg::src_width;
  localparam int     dst_w        = scale_geom_pkg::dst_width;
  localparam int     dst_n        = scale_geom_pkg::dst_pixels;
  localparam int     frame_cycles = 2 * dst_n;
  localparam longint x_factor     = 4918;
  localparam longint y_factor     = 4915;
  localparam longint watchdog_ns  = longint'(4 * frame_cycles + 20000) * 100;

  logic                      clk;
  logic                      rst_n;
  logic                      start = 1'b0;
  scale_geom_pkg::src_addr_t src_addr_left;
  scale_geom_pkg::src_addr_t src_addr_right;
  scale_geom_pkg::pixel_t    src_data_left = '0;
  scale_geom_pkg::pixel_t    src_data_right = '0;
  scale_geom_pkg::pixel_t    pend_left = '0;
  scale_geom_pkg::pixel_t    pend_right = '0;
  scale_geom_pkg::dst_addr_t dst_addr;
  scale_geom_pkg::pixel_t    dst_data;
  logic                      dst_wren;
  logic                      busy;
  logic                      done;

  scale_geom_pkg::pixel_t src_mem [1 << scale_geom_pkg::src_addr_w];
  int                     dst_result [1 << scale_geom_pkg::dst_addr_w];
  int                     write_count [1 << scale_geom_pkg::dst_addr_w];
  int                     write_total;
  int                     done_count;
  int                     writes_at_done;
  integer                 seed = 32'h0194_3083;

  tb_clock_gen u_tb_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  image_scaler u_image_scaler (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .src_addr_left  (src_addr_left),
    .src_addr_right (src_addr_right),
    .src_data_left  (src_data_left),
    .src_data_right (src_data_right),
    .dst_addr       (dst_addr),
    .dst_data       (dst_data),
    .dst_wren       (dst_wren),
    .busy           (busy),
    .done           (done)
  );

  // Data for the address of one cycle shows up during the next cycle
  always @(negedge clk)
  begin
    src_data_left  <= pend_left;
    src_data_right <= pend_right;
    pend_left      <= src_mem[src_addr_left];
    pend_right     <= src_mem[src_addr_right];
  end

  task automatic check_value(string name, int actual, int expected);
    if (actual !== expected)
    begin
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  function automatic int ref_pixel(int x, int y);
    longint mx;
    longint my;
    longint ix;
    longint iy;
    longint fx;
    longint fy;
    longint upper_left;
    longint lower_left;
    longint acc;
    mx  = longint'(x) * x_factor;
    my  = longint'(y) * y_factor;
    ix  = mx / 4096;
    iy  = my / 4096;
    fx  = mx % 4096;
    fy  = my % 4096;
    upper_left = (iy - 1) * src_w + ix - 1;
    lower_left = iy * src_w + ix - 1;
    acc = (4096 - fx) * (4096 - fy) * src_mem[scale_geom_pkg::src_addr_t'(upper_left)]
        + fx * (4096 - fy) * src_mem[scale_geom_pkg::src_addr_t'(upper_left + 1)]
        + (4096 - fx) * fy * src_mem[scale_geom_pkg::src_addr_t'(lower_left)]
        + fx * fy * src_mem[scale_geom_pkg::src_addr_t'(lower_left + 1)];
    return int'(acc >> 24);  // Weights carry 24 fraction bits in total
  endfunction

  task automatic fill_gradient();
    for (int r = 0; r < scale_geom_pkg::src_height; r++)
      for (int c = 0; c < src_w; c++)
        src_mem[scale_geom_pkg::src_addr_t'(r * src_w + c)] =
          scale_geom_pkg::pixel_t'((c + 3 * r) % 256);
  endtask

  task automatic fill_constant(int value);
    for (int i = 0; i < src_w * scale_geom_pkg::src_height; i++)
      src_mem[scale_geom_pkg::src_addr_t'(i)] = scale_geom_pkg::pixel_t'(value);
  endtask

  task automatic fill_random();
    for (int i = 0; i < src_w * scale_geom_pkg::src_height; i++)
      src_mem[scale_geom_pkg::src_addr_t'(i)] = scale_geom_pkg::pixel_t'($random(seed));
  endtask

  task automatic collect_cycle();
    if (dst_wren)
    begin
      dst_result[dst_addr]  = int'(dst_data);
      write_count[dst_addr] = write_count[dst_addr] + 1;
      write_total           = write_total + 1;
    end
    if (done)
    begin
      done_count     = done_count + 1;
      writes_at_done = write_total;
    end
  endtask

  // Called on a falling edge; collects every write until done and a few cycles beyond
  task automatic run_frame();
    int cycles;
    for (int i = 0; i < dst_n; i++)
    begin
      dst_result[scale_geom_pkg::dst_addr_t'(i)]  = -1;
      write_count[scale_geom_pkg::dst_addr_t'(i)] = 0;
    end
    write_total    = 0;
    done_count     = 0;
    writes_at_done = 0;
    cycles         = 0;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_value("busy after start", int'(busy), 1);
    while (done_count == 0)
    begin
      collect_cycle();
      if (cycles > frame_cycles + 100)
      begin
        $display("SOME TESTS FAILED");
        $fatal(1, "Frame did not finish, no done strobe within the expected time");
      end
      @(negedge clk);
      cycles = cycles + 1;
    end
    repeat (10)
    begin
      @(negedge clk);
      collect_cycle();
    end
  endtask

  task automatic check_frame(bit constant_src, int constant_value);
    int                        expected;
    scale_geom_pkg::dst_addr_t a;
    for (int i = 0; i < dst_n; i++)
    begin
      a = scale_geom_pkg::dst_addr_t'(i);
      if (constant_src)
        expected = constant_value;
      else
        expected = ref_pixel(i % dst_w + 1, i / dst_w + 1);
      if (write_count[a] != 1)
        check_value($sformatf("write count of dst_addr %0d", i), write_count[a], 1);
      if (dst_result[a] != expected)
        check_value($sformatf("dst_data at dst_addr %0d", i), dst_result[a], expected);
    end
    check_value("number of dst_wren writes", write_total, dst_n);
    check_value("done pulses", done_count, 1);
    check_value("writes before done", writes_at_done, dst_n);
    check_value("busy", int'(busy), 0);
  endtask

  task automatic test_idle_after_reset();
    repeat (4)
    begin
      check_value("dst_wren", int'(dst_wren), 0);
      check_value("busy", int'(busy), 0);
      check_value("done", int'(done), 0);
      @(negedge clk);
    end
  endtask

  task automatic test_gradient_frame();
    fill_gradient();
    run_frame();
    check_frame(1'b0, 0);
  endtask

  task automatic test_constant_frame();
    fill_constant(77);
    run_frame();
    check_frame(1'b1, 77);
  endtask

  task automatic test_random_frame();
    fill_random();
    run_frame();
    check_frame(1'b0, 0);
  endtask

  task automatic test_restart();
    run_frame();  // Same random source as the previous frame
    check_frame(1'b0, 0);
  endtask

  initial
  begin
    #(watchdog_ns);
    $display("SOME TESTS FAILED");
    $fatal(1, "Watchdog expired before the tests finished");
  end

  initial
  begin
    @(posedge rst_n);
    @(negedge clk);
    test_idle_after_reset();
    test_gradient_frame();
    test_constant_frame();
    test_random_frame();
    test_restart();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== project.f ====
design/scale_geom_pkg.sv
design/scale_fixed_pkg.sv
design/raster_scan.sv
design/coord_mapper.sv
design/pixel_gather.sv
design/bilinear_blend.sv
design/image_scaler.sv
verification/tb_clock_gen.sv
verification/image_scaler_asserts.sv
verification/image_scaler_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the image scaler testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module image_scaler_tb -f project.f -o image_scaler_sim > build.log 2>&1 \
  && ./obj_dir/image_scaler_sim > sim.log 2>&1 \
  || echo "SOME TESTS FAILED" >> sim.log
grep -q "SOME TESTS FAILED" sim.log && echo "Simulation failed, see sim.log and build.log" && exit 1
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
